/* Makefile */
# Verilator build and run for the interrupt unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := irq_ctrl_tb
FILELIST  := irq_ctrl.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/irq_arbiter.sv */
// Interrupt arbiter
// Fixed priority pick of the pending enabled interrupt, registered
`timescale 1ns/10ps

module irq_arbiter (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  irq_pkg::irq_vec_t pend_en_i,
  output irq_pkg::irq_sel_t sel_o
);

  import irq_pkg::*;

  // Combinational winner
  irq_sel_t sel_d;
  // Registered winner
  irq_sel_t sel_q;

  // --------------------
  // Priority encoder
  // --------------------
  // Order is 31 down to 16, then 11, then 3, then 7
  // Lowest priority is checked first and overwritten by higher ones
  always_comb begin
    sel_d.valid = 1'b0;
    sel_d.id    = '0;

    // Timer interrupt, lowest
    if (pend_en_i[7]) begin
      sel_d.valid = 1'b1;
      sel_d.id    = irq_id_t'(7);
    end

    // Software interrupt
    if (pend_en_i[3]) begin
      sel_d.valid = 1'b1;
      sel_d.id    = irq_id_t'(3);
    end

    // External interrupt
    if (pend_en_i[11]) begin
      sel_d.valid = 1'b1;
      sel_d.id    = irq_id_t'(11);
    end

    // Fast interrupts, higher index wins
    for (int unsigned i = 16; i < NUM_IRQ; i++) begin
      if (pend_en_i[i]) begin
        sel_d.valid = 1'b1;
        sel_d.id    = irq_id_t'(i);
      end
    end
  end

  // --------------------
  // Output register
  // --------------------
  // One cycle behind mip and mie
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_d;
    end
  end

  assign sel_o = sel_q;

endmodule

/* design/irq_csr.sv */
// Interrupt CSR block
// Samples the interrupt lines into mip, holds mie, mstatus and mtvec,
// and performs trap entry with the ack pulse and the mret restore
`timescale 1ns/10ps

module irq_csr (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  irq_pkg::irq_vec_t   irq_i,
  input  irq_pkg::csr_wr_t    csr_wr_i,
  input  logic                mret_i,
  input  irq_pkg::irq_sel_t   sel_i,
  output irq_pkg::irq_vec_t   pend_en_o,
  output irq_pkg::csr_state_t csr_o,
  output logic                irq_ack_o,
  output irq_pkg::irq_id_t    irq_id_o
);

  import irq_pkg::*;

  // Register state
  irq_vec_t    mip_q;
  irq_vec_t    mie_q;
  logic        mstatus_mie_q;
  logic        mstatus_mpie_q;
  mtvec_mode_t mtvec_mode_q;
  logic [5:0]  mcause_q;
  logic        irq_ack_q;
  irq_id_t     irq_id_q;

  // Decoded write strobes
  logic wr_mstatus;
  logic wr_mie;
  logic wr_mtvec;

  // Interrupt taken this cycle
  logic take_irq;

  // --------------------
  // Write decode
  // --------------------
  assign wr_mstatus = csr_wr_i.we && (csr_wr_i.addr == CSR_MSTATUS);
  assign wr_mie     = csr_wr_i.we && (csr_wr_i.addr == CSR_MIE);
  assign wr_mtvec   = csr_wr_i.we && (csr_wr_i.addr == CSR_MTVEC);

  // Winner from the arbiter is taken only with global enable set
  assign take_irq = sel_i.valid && mstatus_mie_q;

  // --------------------
  // mip and mie
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
      mie_q <= '0;
    end else begin
      // Reserved lines never show up as pending
      mip_q <= irq_i & IRQ_VALID_MASK;
      // Reserved enable bits read as zero
      if (wr_mie) begin
        mie_q <= csr_wr_i.data & IRQ_VALID_MASK;
      end
    end
  end

  // Local enable applied to pending, feeds arbiter and WFI wakeup
  assign pend_en_o = mip_q & mie_q;

  // --------------------
  // mstatus
  // --------------------
  // Software write first, then trap entry, then mret
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (wr_mstatus) begin
      mstatus_mie_q  <= csr_wr_i.data[MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wr_i.data[MSTATUS_MPIE_BIT];
    end else if (take_irq) begin
      // Save global enable and mask further interrupts
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_i) begin
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end
  end

  // --------------------
  // mtvec mode, stored and read back only
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtvec_mode_q <= '0;
    end else if (wr_mtvec) begin
      mtvec_mode_q <= csr_wr_i.data[1:0];
    end
  end

  // --------------------
  // Trap entry, mcause and ack
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mcause_q  <= '0;
      irq_ack_q <= 1'b0;
      irq_id_q  <= '0;
    end else begin
      // MIE drops on the same edge, so this is a single cycle pulse
      irq_ack_q <= take_irq;
      if (take_irq) begin
        mcause_q <= {1'b1, sel_i.id};
        // ID holds until the next ack
        irq_id_q <= sel_i.id;
      end
    end
  end

  assign irq_ack_o = irq_ack_q;
  assign irq_id_o  = irq_id_q;

  // Architectural view
  always_comb begin
    csr_o.mip          = mip_q;
    csr_o.mie          = mie_q;
    csr_o.mstatus_mie  = mstatus_mie_q;
    csr_o.mstatus_mpie = mstatus_mpie_q;
    csr_o.mtvec_mode   = mtvec_mode_q;
    csr_o.mcause       = mcause_q;
  end

endmodule

/* design/irq_ctrl.sv */
// Machine-mode interrupt unit, top level
// Connects the CSR block, the priority arbiter and the WFI tracker
`timescale 1ns/10ps

module irq_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Interrupt lines
  input  irq_pkg::irq_vec_t   irq_i,

  // CSR write port and trap return
  input  irq_pkg::csr_wr_t    csr_wr_i,
  input  logic                mret_i,

  // Decode stage instruction
  input  logic                instr_valid_i,
  input  irq_pkg::word_t      instr_rdata_i,
  input  logic                branch_taken_i,

  // Debug request, wakes from WFI
  input  logic                debug_req_i,

  // Architectural state and interrupt handshake
  output irq_pkg::csr_state_t csr_o,
  output logic                irq_ack_o,
  output irq_pkg::irq_id_t    irq_id_o,

  // Sleep status
  output logic                core_sleep_o
);

  import irq_pkg::*;

  // Pending and enabled interrupts
  irq_vec_t pend_en;
  // Registered arbiter winner
  irq_sel_t sel;

  // --------------------
  // CSRs and trap entry
  // --------------------
  irq_csr irq_csr_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .csr_wr_i  (csr_wr_i),
    .mret_i    (mret_i),
    .sel_i     (sel),
    .pend_en_o (pend_en),
    .csr_o     (csr_o),
    .irq_ack_o (irq_ack_o),
    .irq_id_o  (irq_id_o)
  );

  // --------------------
  // Arbitration
  // --------------------
  irq_arbiter irq_arbiter_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .pend_en_i (pend_en),
    .sel_o     (sel)
  );

  // --------------------
  // WFI sleep
  // --------------------
  irq_wfi_tracker irq_wfi_tracker_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_valid_i  (instr_valid_i),
    .instr_rdata_i  (instr_rdata_i),
    .branch_taken_i (branch_taken_i),
    .pend_en_i      (pend_en),
    .debug_req_i    (debug_req_i),
    .core_sleep_o   (core_sleep_o)
  );

endmodule

/* design/irq_pkg.sv */
// Interrupt unit package
// Architectural sizes, CSR encodings and the structs shared by the
// machine-mode interrupt blocks
package irq_pkg;

  // --------------------
  // Sizes and constants
  // --------------------

  // Number of interrupt lines into the core
  localparam int unsigned NUM_IRQ = 32;

  // Implemented lines: software 3, timer 7, external 11, fast 16 to 31
  localparam logic [NUM_IRQ-1:0] IRQ_VALID_MASK = 32'hffff_0888;

  // Encoding of the WFI instruction
  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;

  // Bit positions inside mstatus
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // --------------------
  // Vector types
  // --------------------
  typedef logic [NUM_IRQ-1:0] irq_vec_t;
  typedef logic [4:0]         irq_id_t;
  typedef logic [31:0]        word_t;
  typedef logic [1:0]         mtvec_mode_t;

  // Writable CSRs, encoded by their machine-mode address
  typedef enum logic [11:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MIE     = 12'h304,
    CSR_MTVEC   = 12'h305
  } csr_addr_e;

  // --------------------
  // Structs
  // --------------------

  // One CSR write strobe with its address and data
  typedef struct packed {
    logic      we;
    csr_addr_e addr;
    word_t     data;
  } csr_wr_t;

  // Arbiter result
  typedef struct packed {
    logic    valid;
    irq_id_t id;
  } irq_sel_t;

  // Architectural state as seen from outside
  // mcause is the interrupt flag above the ID
  typedef struct packed {
    irq_vec_t    mip;
    irq_vec_t    mie;
    logic        mstatus_mie;
    logic        mstatus_mpie;
    mtvec_mode_t mtvec_mode;
    logic [5:0]  mcause;
  } csr_state_t;

endpackage

/* design/irq_wfi_tracker.sv */
// WFI tracker
// Decodes WFI in the decode stage and holds the core asleep until
// an enabled interrupt is pending or debug is requested
`timescale 1ns/10ps

module irq_wfi_tracker (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              instr_valid_i,
  input  irq_pkg::word_t    instr_rdata_i,
  input  logic              branch_taken_i,
  input  irq_pkg::irq_vec_t pend_en_i,
  input  logic              debug_req_i,
  output logic              core_sleep_o
);

  import irq_pkg::*;

  typedef enum logic {
    RUNNING,
    SLEEPING
  } wfi_state_e;

  wfi_state_e state_q;
  wfi_state_e state_d;

  // Accepted WFI in decode
  logic wfi_accept;
  // Wakeup request
  logic wake;

  // --------------------
  // Decode
  // --------------------
  // A taken branch flushes the WFI in decode
  assign wfi_accept = instr_valid_i && (instr_rdata_i == WFI_INSTR) && !branch_taken_i;

  // Global MIE plays no part in wakeup
  assign wake = (|pend_en_i) || debug_req_i;

  // --------------------
  // Sleep FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    // WFI wins over a wakeup in the same cycle
    if (wfi_accept) begin
      state_d = SLEEPING;
    end else if ((state_q == SLEEPING) && wake) begin
      state_d = RUNNING;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RUNNING;
    end else begin
      state_q <= state_d;
    end
  end

  assign core_sleep_o = (state_q == SLEEPING);

endmodule

/* irq_ctrl.f */
design/irq_pkg.sv
design/irq_arbiter.sv
design/irq_csr.sv
design/irq_wfi_tracker.sv
design/irq_ctrl.sv
verification/irq_ctrl_tb.sv

/* verification/irq_ctrl_tb.sv */
// Testbench for the machine-mode interrupt unit
// Runs a table of mie, MIE and irq patterns with expected ack and ID,
// then checks mret re-entry and WFI sleep and wakeup
`timescale 1ns/10ps

module irq_ctrl_tb;

  import irq_pkg::*;

  localparam int unsigned CLK_PERIOD     = 20;
  localparam int unsigned NUM_DIRECTED   = 10;
  localparam int unsigned NUM_RANDOM     = 6;
  localparam int unsigned NUM_ROWS       = NUM_DIRECTED + NUM_RANDOM;
  localparam int unsigned CYCLES_PER_ROW = 16;
  // Reset, mask, mret and WFI sections plus slack
  localparam int unsigned EXTRA_CYCLES   = 200;
  localparam int unsigned WATCHDOG_NS    =
    (NUM_ROWS * CYCLES_PER_ROW + EXTRA_CYCLES) * CLK_PERIOD;

  // One stimulus row with its expected result
  typedef struct packed {
    irq_vec_t mie;
    logic     global_en;
    irq_vec_t irq;
    logic     exp_ack;
    irq_id_t  exp_id;
  } row_t;

  // DUT signals
  logic       clk_i;
  logic       rst_ni;
  irq_vec_t   irq_i;
  csr_wr_t    csr_wr_i;
  logic       mret_i;
  logic       instr_valid_i;
  word_t      instr_rdata_i;
  logic       branch_taken_i;
  logic       debug_req_i;
  csr_state_t csr_o;
  logic       irq_ack_o;
  irq_id_t    irq_id_o;
  logic       core_sleep_o;

  row_t rows [NUM_ROWS];
  int   seed = 49;
  int   checks = 0;
  int   errors = 0;

  irq_ctrl irq_ctrl_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .irq_i          (irq_i),
    .csr_wr_i       (csr_wr_i),
    .mret_i         (mret_i),
    .instr_valid_i  (instr_valid_i),
    .instr_rdata_i  (instr_rdata_i),
    .branch_taken_i (branch_taken_i),
    .debug_req_i    (debug_req_i),
    .csr_o          (csr_o),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o),
    .core_sleep_o   (core_sleep_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------

  // Inputs change 2 ns after the rising edge, outputs are stable there
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic compare_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s expected 0x%h, got 0x%h", $time, name, exp, got);
    end
  endtask

  // Single cycle write strobe
  task automatic write_csr(input csr_addr_e addr, input word_t data);
    csr_wr_i.we   = 1'b1;
    csr_wr_i.addr = addr;
    csr_wr_i.data = data;
    next_cycle();
    csr_wr_i.we   = 1'b0;
    csr_wr_i.data = '0;
  endtask

  function automatic word_t mstatus_word(input logic global_en);
    word_t w;
    w = '0;
    w[MSTATUS_MIE_BIT] = global_en;
    return w;
  endfunction

  task automatic count_acks(input int cycles, output int acks);
    acks = 0;
    repeat (cycles) begin
      next_cycle();
      if (irq_ack_o === 1'b1) begin
        acks++;
      end
    end
  endtask

  // Waits for core_sleep_o to reach a level, bounded by a cycle count
  task automatic wait_sleep(input logic level, input int max_cycles, input string cause);
    int n;
    n = 0;
    while (core_sleep_o !== level && n < max_cycles) begin
      next_cycle();
      n++;
    end
    checks++;
    if (core_sleep_o !== level) begin
      errors++;
      $display("Error at time %0t: core_sleep_o expected %0b within %0d cycles after %s, got %0b",
               $time, level, max_cycles, cause, core_sleep_o);
    end
  endtask

  // Reference order: 31 down to 16, then 11, then 3, then 7
  function automatic irq_id_t ref_winner(input irq_vec_t pend);
    irq_id_t id;
    logic    found;
    id    = '0;
    found = 1'b0;
    for (int i = 31; i >= 16; i--) begin
      if (!found && pend[i]) begin
        id    = irq_id_t'(i);
        found = 1'b1;
      end
    end
    if (!found && pend[11]) begin
      id    = irq_id_t'(11);
      found = 1'b1;
    end
    if (!found && pend[3]) begin
      id    = irq_id_t'(3);
      found = 1'b1;
    end
    if (!found && pend[7]) begin
      id = irq_id_t'(7);
    end
    return id;
  endfunction

  function automatic row_t make_row(input irq_vec_t mie, input logic global_en,
                                    input irq_vec_t irq, input logic exp_ack,
                                    input irq_id_t exp_id);
    row_t r;
    r.mie       = mie;
    r.global_en = global_en;
    r.irq       = irq;
    r.exp_ack   = exp_ack;
    r.exp_id    = exp_id;
    return r;
  endfunction

  // --------------------
  // Stimulus table
  // --------------------
  task automatic fill_table();
    irq_vec_t mie_r;
    irq_vec_t irq_r;
    irq_vec_t pend;
    word_t    rnd;
    logic     en;
    // mie, MIE, irq, ack, ID
    rows[0] = make_row(32'hffff_ffff, 1'b1, 32'h0000_0088, 1'b1, 5'd3);
    rows[1] = make_row(32'hffff_ffff, 1'b1, 32'h0000_0880, 1'b1, 5'd11);
    rows[2] = make_row(32'hffff_ffff, 1'b1, 32'h8001_0008, 1'b1, 5'd31);
    rows[3] = make_row(32'hffff_ffff, 1'b1, 32'h0003_0800, 1'b1, 5'd17);
    rows[4] = make_row(32'h0000_0080, 1'b1, 32'hffff_ffff, 1'b1, 5'd7);
    // Global enable off
    rows[5] = make_row(32'hffff_ffff, 1'b0, 32'h0001_0000, 1'b0, 5'd0);
    // Pending but not enabled
    rows[6] = make_row(32'h0000_0008, 1'b1, 32'h0000_0800, 1'b0, 5'd0);
    // Reserved lines only
    rows[7] = make_row(32'hffff_ffff, 1'b1, 32'h0000_7777, 1'b0, 5'd0);
    rows[8] = make_row(32'h0000_0880, 1'b1, 32'h0000_0088, 1'b1, 5'd7);
    rows[9] = make_row(32'hffff_0000, 1'b1, 32'h00f0_0888, 1'b1, 5'd23);
    for (int r = NUM_DIRECTED; r < NUM_ROWS; r++) begin
      mie_r = $random(seed);
      irq_r = $random(seed);
      rnd   = $random(seed);
      en    = rnd[0];
      pend  = irq_r & mie_r & IRQ_VALID_MASK;
      rows[r] = make_row(mie_r, en, irq_r, en && (pend != '0), ref_winner(pend));
    end
  endtask

  // Write, drive, watch for the ack, check, then drop and return
  task automatic run_row(input int idx, input row_t row);
    logic [5:0] mcause_before;
    int         acks;
    write_csr(CSR_MIE, row.mie);
    write_csr(CSR_MSTATUS, mstatus_word(row.global_en));
    mcause_before = csr_o.mcause;
    irq_i = row.irq;
    count_acks(4, acks);
    compare_value($sformatf("row %0d irq_ack_o pulses", idx), word_t'(acks),
                  word_t'(row.exp_ack));
    if (row.exp_ack) begin
      compare_value($sformatf("row %0d irq_id_o", idx), word_t'(irq_id_o),
                    word_t'(row.exp_id));
      compare_value($sformatf("row %0d mcause", idx), word_t'(csr_o.mcause),
                    word_t'({1'b1, row.exp_id}));
      compare_value($sformatf("row %0d mstatus.MIE", idx), word_t'(csr_o.mstatus_mie), '0);
      compare_value($sformatf("row %0d mstatus.MPIE", idx), word_t'(csr_o.mstatus_mpie), 1);
    end else begin
      compare_value($sformatf("row %0d mcause", idx), word_t'(csr_o.mcause),
                    word_t'(mcause_before));
      compare_value($sformatf("row %0d mstatus.MIE", idx), word_t'(csr_o.mstatus_mie),
                    word_t'(row.global_en));
    end
    // Let the stale winner drain before re-enabling
    irq_i = '0;
    repeat (3) next_cycle();
    mret_i = 1'b1;
    next_cycle();
    mret_i = 1'b0;
    if (row.exp_ack) begin
      compare_value($sformatf("row %0d mstatus.MIE after mret", idx),
                    word_t'(csr_o.mstatus_mie), 1);
    end
    count_acks(2, acks);
    compare_value($sformatf("row %0d irq_ack_o after mret", idx), word_t'(acks), '0);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    int acks;
    rst_ni         = 1'b0;
    irq_i          = '0;
    csr_wr_i.we    = 1'b0;
    csr_wr_i.addr  = CSR_MSTATUS;
    csr_wr_i.data  = '0;
    mret_i         = 1'b0;
    instr_valid_i  = 1'b0;
    instr_rdata_i  = '0;
    branch_taken_i = 1'b0;
    debug_req_i    = 1'b0;
    fill_table();

    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    // Reset state
    compare_value("csr_o mip", csr_o.mip, '0);
    compare_value("csr_o mie", csr_o.mie, '0);
    compare_value("csr_o status bits",
                  word_t'({csr_o.mstatus_mie, csr_o.mstatus_mpie, csr_o.mtvec_mode}), '0);
    compare_value("csr_o mcause", word_t'(csr_o.mcause), '0);
    compare_value("irq_ack_o", word_t'(irq_ack_o), '0);
    compare_value("core_sleep_o", word_t'(core_sleep_o), '0);

    // Reserved bits stay clear in mie and mip
    write_csr(CSR_MIE, 32'hffff_ffff);
    compare_value("mie after all-ones write", csr_o.mie, IRQ_VALID_MASK);
    write_csr(CSR_MTVEC, 32'h0000_0001);
    compare_value("mtvec mode", word_t'(csr_o.mtvec_mode), 1);
    irq_i = '1;
    next_cycle();
    compare_value("mip with all lines high", csr_o.mip, IRQ_VALID_MASK);
    irq_i = '0;
    repeat (3) next_cycle();

    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r, rows[r]);
    end

    // --------------------
    // mret re-entry with the line still high
    // --------------------
    write_csr(CSR_MIE, 32'h0001_0000);
    write_csr(CSR_MSTATUS, mstatus_word(1'b1));
    irq_i = 32'h0001_0000;
    count_acks(4, acks);
    compare_value("first irq_ack_o pulses", word_t'(acks), 1);
    compare_value("mstatus.MPIE after ack", word_t'(csr_o.mstatus_mpie), 1);
    mret_i = 1'b1;
    next_cycle();
    mret_i = 1'b0;
    compare_value("mstatus.MIE after mret", word_t'(csr_o.mstatus_mie), 1);
    count_acks(3, acks);
    compare_value("irq_ack_o pulses after mret", word_t'(acks), 1);
    compare_value("irq_id_o after re-entry", word_t'(irq_id_o), 16);
    irq_i = '0;
    write_csr(CSR_MSTATUS, mstatus_word(1'b0));
    repeat (3) next_cycle();

    // --------------------
    // WFI sleep and wakeup
    // --------------------
    write_csr(CSR_MIE, 32'h0000_0800);
    // Flushed by a taken branch
    instr_valid_i  = 1'b1;
    instr_rdata_i  = WFI_INSTR;
    branch_taken_i = 1'b1;
    next_cycle();
    instr_valid_i  = 1'b0;
    branch_taken_i = 1'b0;
    compare_value("core_sleep_o after flushed WFI", word_t'(core_sleep_o), '0);
    instr_valid_i = 1'b1;
    next_cycle();
    instr_valid_i = 1'b0;
    compare_value("core_sleep_o after WFI", word_t'(core_sleep_o), 1);
    repeat (2) next_cycle();
    compare_value("core_sleep_o while idle", word_t'(core_sleep_o), 1);
    // Enabled pending line wakes the core with MIE clear
    irq_i = 32'h0000_0800;
    wait_sleep(1'b0, 4, "enabled interrupt");
    count_acks(4, acks);
    compare_value("irq_ack_o pulses with MIE clear", word_t'(acks), '0);
    irq_i = '0;
    repeat (3) next_cycle();
    // Second sleep ends on debug request
    instr_valid_i = 1'b1;
    next_cycle();
    instr_valid_i = 1'b0;
    compare_value("core_sleep_o after second WFI", word_t'(core_sleep_o), 1);
    next_cycle();
    debug_req_i = 1'b1;
    wait_sleep(1'b0, 2, "debug request");
    debug_req_i = 1'b0;
    next_cycle();
    compare_value("core_sleep_o after debug wakeup", word_t'(core_sleep_o), '0);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
